// File: gfx_vga_stripe.f
+incdir+src
src/fb_pkg.sv
src/vga_pkg.sv
src/stripe_ctrl.sv
src/fb_bank.sv
src/scan_timing.sv
src/pixel_fifo.sv
src/gfx_vga_stripe.sv
tb/gfx_vga_stripe_chk.sv
tb/tb_gfx_vga_stripe.sv

// File: run.sh
#!/bin/sh
# build and run the gfx_vga_stripe testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f gfx_vga_stripe.f \
  --top-module tb_gfx_vga_stripe \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: src/fb_bank.sv
`timescale 1ns/1ns
`include "gfx_defines.svh"

module fb_bank (
  input  logic              clk,
  input  fb_pkg::bank_req_t req,
  output fb_pkg::pixel_t    rdata
);
  localparam int WORDS = `GFX_H_VISIBLE * `GFX_V_VISIBLE / `GFX_NUM_S;

  fb_pkg::pixel_t mem [WORDS];

  // single port, one op per cycle
  always_ff @(posedge clk) begin
    case (req.op)
      fb_pkg::op_write: begin
        mem[req.word] <= req.wdata;
      end
      fb_pkg::op_read: begin
        rdata <= mem[req.word];
      end
      default: begin
      end
    endcase
  end

endmodule

// File: src/fb_pkg.sv
`include "gfx_defines.svh"

package fb_pkg;

  // 4 bits per colour channel
  typedef struct packed {
    logic [`GFX_PIXEL_BITS/3-1:0] red;
    logic [`GFX_PIXEL_BITS/3-1:0] grn;
    logic [`GFX_PIXEL_BITS/3-1:0] blu;
  } pixel_t;

  // one drawing client write, by coordinate
  typedef struct packed {
    logic [`GFX_X_BITS-1:0] x;
    logic [`GFX_Y_BITS-1:0] y;
    pixel_t                 color;
  } gfx_write_t;

  typedef enum logic [1:0] {
    op_idle,
    op_read,
    op_write
  } bank_op_e;

  // access to a single bank, at most one per cycle
  typedef struct packed {
    bank_op_e                  op;
    logic [`GFX_WORD_BITS-1:0] word;
    pixel_t                    wdata;
  } bank_req_t;

endpackage

// File: src/gfx_defines.svh
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// frame buffer striping
`define GFX_NUM_S       2
`define GFX_PIXEL_BITS  12

// horizontal timing, in pixels
`define GFX_H_VISIBLE   16
`define GFX_H_FRONT     2
`define GFX_H_SYNC      3
`define GFX_H_BACK      3
`define GFX_H_WHOLE     24

// vertical timing, in lines
`define GFX_V_VISIBLE   8
`define GFX_V_FRONT     1
`define GFX_V_SYNC      2
`define GFX_V_BACK      1
`define GFX_V_WHOLE     12

// coordinate and bank word widths
`define GFX_X_BITS      4
`define GFX_Y_BITS      3
`define GFX_WORD_BITS   6

// output fifo, room for two in-flight beats above the threshold
`define GFX_FIFO_DEPTH  8
`define GFX_FIFO_AFULL  5

`define GFX_PIXEL_DIV   2

`endif

// File: src/gfx_vga_stripe.sv
`timescale 1ns/1ns
`include "gfx_defines.svh"

module gfx_vga_stripe (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               vga_enable,
  input  fb_pkg::gfx_write_t gfx_wr,
  input  logic               gfx_valid,
  output logic               gfx_ready,
  output vga_pkg::vga_beat_t vga_out
);
  // scan generator to controller
  vga_pkg::scan_item_t scan_item;
  logic                scan_step;

  // controller to banks
  fb_pkg::bank_req_t [`GFX_NUM_S-1:0] bank_req;
  fb_pkg::pixel_t    [`GFX_NUM_S-1:0] bank_rdata;

  // controller to output fifo
  logic                fifo_afull;
  logic                fifo_push;
  vga_pkg::vga_beat_t  fifo_beat;

  stripe_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .vga_enable (vga_enable),
    .gfx_wr     (gfx_wr),
    .gfx_valid  (gfx_valid),
    .gfx_ready  (gfx_ready),
    .scan_item  (scan_item),
    .scan_step  (scan_step),
    .bank_req   (bank_req),
    .bank_rdata (bank_rdata),
    .fifo_afull (fifo_afull),
    .fifo_push  (fifo_push),
    .fifo_beat  (fifo_beat)
  );

  for (genvar i = 0; i < `GFX_NUM_S; i++) begin : gen_bank
    fb_bank u_bank (
      .clk   (clk),
      .req   (bank_req[i]),
      .rdata (bank_rdata[i])
    );
  end

  scan_timing u_scan (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (scan_step),
    .item  (scan_item)
  );

  pixel_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (fifo_push),
    .beat_in (fifo_beat),
    .afull   (fifo_afull),
    .vga_out (vga_out)
  );

endmodule

// File: src/pixel_fifo.sv
`timescale 1ns/1ns
`include "gfx_defines.svh"

module pixel_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push,
  input  vga_pkg::vga_beat_t beat_in,
  output logic               afull,
  output vga_pkg::vga_beat_t vga_out
);
  localparam int PTR_BITS = $clog2(`GFX_FIFO_DEPTH);
  localparam int DIV_BITS = $clog2(`GFX_PIXEL_DIV + 1);

  vga_pkg::vga_beat_t  mem [`GFX_FIFO_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;
  logic [DIV_BITS-1:0] div_cnt;
  logic                tick;
  logic                wr_en;
  logic                pop;

  assign afull = (count >= (PTR_BITS + 1)'(`GFX_FIFO_AFULL));
  assign wr_en = push && (count != (PTR_BITS + 1)'(`GFX_FIFO_DEPTH));
  // pixel rate strobe
  assign tick  = (div_cnt == DIV_BITS'(`GFX_PIXEL_DIV - 1));
  // empty at a tick keeps the last beat on the output
  assign pop   = tick && (count != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= beat_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      div_cnt <= '0;
      vga_out <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, pixel: '0};
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr  <= rd_ptr + 1'b1;
        vga_out <= mem[rd_ptr];
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/scan_timing.sv
`timescale 1ns/1ns
`include "gfx_defines.svh"

module scan_timing (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                step,
  output vga_pkg::scan_item_t item
);
  localparam int BANK_BITS = $clog2(`GFX_NUM_S);

  vga_pkg::scan_state_e      h_state;
  vga_pkg::scan_state_e      v_state;
  logic [`GFX_X_BITS-1:0]    h_cnt;
  logic [`GFX_Y_BITS-1:0]    v_cnt;
  logic [BANK_BITS-1:0]      pix_bank;
  logic [`GFX_WORD_BITS-1:0] pix_word;
  logic                      h_end;
  logic                      v_end;

  function automatic vga_pkg::scan_state_e next_phase(input vga_pkg::scan_state_e s);
    case (s)
      vga_pkg::st_active: return vga_pkg::st_front;
      vga_pkg::st_front:  return vga_pkg::st_sync;
      vga_pkg::st_sync:   return vga_pkg::st_back;
      default:            return vga_pkg::st_active;
    endcase
  endfunction

  // last count of each phase
  function automatic logic [`GFX_X_BITS-1:0] h_last(input vga_pkg::scan_state_e s);
    case (s)
      vga_pkg::st_active: return `GFX_X_BITS'(`GFX_H_VISIBLE - 1);
      vga_pkg::st_front:  return `GFX_X_BITS'(`GFX_H_FRONT - 1);
      vga_pkg::st_sync:   return `GFX_X_BITS'(`GFX_H_SYNC - 1);
      default:            return `GFX_X_BITS'(`GFX_H_BACK - 1);
    endcase
  endfunction

  function automatic logic [`GFX_Y_BITS-1:0] v_last(input vga_pkg::scan_state_e s);
    case (s)
      vga_pkg::st_active: return `GFX_Y_BITS'(`GFX_V_VISIBLE - 1);
      vga_pkg::st_front:  return `GFX_Y_BITS'(`GFX_V_FRONT - 1);
      vga_pkg::st_sync:   return `GFX_Y_BITS'(`GFX_V_SYNC - 1);
      default:            return `GFX_Y_BITS'(`GFX_V_BACK - 1);
    endcase
  endfunction

  assign h_end = (h_cnt == h_last(h_state));
  assign v_end = (v_cnt == v_last(v_state));

  assign item.hsync = (h_state != vga_pkg::st_sync);
  assign item.vsync = (v_state != vga_pkg::st_sync);
  assign item.de    = (h_state == vga_pkg::st_active) && (v_state == vga_pkg::st_active);
  assign item.bank  = pix_bank;
  assign item.word  = pix_word;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_state  <= vga_pkg::st_active;
      v_state  <= vga_pkg::st_active;
      h_cnt    <= '0;
      v_cnt    <= '0;
      pix_bank <= '0;
      pix_word <= '0;
    end else if (step) begin
      if (h_end) begin
        h_cnt   <= '0;
        h_state <= next_phase(h_state);
        // line done, move the vertical phase
        if (h_state == vga_pkg::st_back) begin
          if (v_end) begin
            v_cnt   <= '0;
            v_state <= next_phase(v_state);
          end else begin
            v_cnt <= v_cnt + 1'b1;
          end
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      // running stripe address instead of y*width+x
      if (item.de) begin
        if (pix_bank == BANK_BITS'(`GFX_NUM_S - 1)) begin
          pix_bank <= '0;
          pix_word <= pix_word + 1'b1;
        end else begin
          pix_bank <= pix_bank + 1'b1;
        end
      end else if (h_end && h_state == vga_pkg::st_back && v_end
                   && v_state == vga_pkg::st_back) begin
        pix_bank <= '0;
        pix_word <= '0;
      end
    end
  end

endmodule

// File: src/stripe_ctrl.sv
`timescale 1ns/1ns
`include "gfx_defines.svh"

module stripe_ctrl (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  vga_enable,
  input  fb_pkg::gfx_write_t                    gfx_wr,
  input  logic                                  gfx_valid,
  output logic                                  gfx_ready,
  input  vga_pkg::scan_item_t                   scan_item,
  output logic                                  scan_step,
  output fb_pkg::bank_req_t [`GFX_NUM_S-1:0]    bank_req,
  input  fb_pkg::pixel_t    [`GFX_NUM_S-1:0]    bank_rdata,
  input  logic                                  fifo_afull,
  output logic                                  fifo_push,
  output vga_pkg::vga_beat_t                    fifo_beat
);
  localparam int BANK_BITS = $clog2(`GFX_NUM_S);
  localparam int ADDR_BITS = `GFX_X_BITS + `GFX_Y_BITS;

  logic [ADDR_BITS-1:0]      wr_lin;
  logic [BANK_BITS-1:0]      wr_bank;
  logic [`GFX_WORD_BITS-1:0] wr_word;

  logic                      pend_valid;
  logic [BANK_BITS-1:0]      pend_bank;
  logic [`GFX_WORD_BITS-1:0] pend_word;
  fb_pkg::pixel_t            pend_color;
  logic                      pend_issue;
  logic                      init_done;

  logic                      rd_en;
  logic                      s1_valid;
  vga_pkg::scan_item_t       s1_item;

  // linear pixel address, then stripe over the banks
  assign wr_lin  = ADDR_BITS'(gfx_wr.y) * ADDR_BITS'(`GFX_H_VISIBLE) + ADDR_BITS'(gfx_wr.x);
  assign wr_bank = BANK_BITS'(wr_lin % ADDR_BITS'(`GFX_NUM_S));
  assign wr_word = `GFX_WORD_BITS'(wr_lin / ADDR_BITS'(`GFX_NUM_S));

  // fifo level is the only stall on the scan
  assign scan_step = vga_enable && !fifo_afull;
  assign rd_en     = scan_step && scan_item.de;

  // held write goes out unless the scan reads the same bank
  assign pend_issue = pend_valid && !(rd_en && (scan_item.bank == pend_bank));
  assign gfx_ready  = init_done && (!pend_valid || pend_issue);

  always_comb begin
    for (int b = 0; b < `GFX_NUM_S; b++) begin
      bank_req[b].op    = fb_pkg::op_idle;
      bank_req[b].word  = scan_item.word;
      bank_req[b].wdata = pend_color;
      if (rd_en && (scan_item.bank == BANK_BITS'(b))) begin
        bank_req[b].op = fb_pkg::op_read;
      end else if (pend_valid && (pend_bank == BANK_BITS'(b))) begin
        bank_req[b].op   = fb_pkg::op_write;
        bank_req[b].word = pend_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      init_done  <= 1'b0;
      pend_valid <= 1'b0;
      s1_valid   <= 1'b0;
      fifo_push  <= 1'b0;
    end else begin
      init_done <= 1'b1;
      if (gfx_valid && gfx_ready) begin
        pend_valid <= 1'b1;
      end else if (pend_issue) begin
        pend_valid <= 1'b0;
      end
      s1_valid  <= scan_step;
      fifo_push <= s1_valid;
    end
  end

  // payload of the held write and of the read pipeline
  always_ff @(posedge clk) begin
    if (gfx_valid && gfx_ready) begin
      pend_bank  <= wr_bank;
      pend_word  <= wr_word;
      pend_color <= gfx_wr.color;
    end
    s1_item         <= scan_item;
    fifo_beat.hsync <= s1_item.hsync;
    fifo_beat.vsync <= s1_item.vsync;
    fifo_beat.de    <= s1_item.de;
    // blanking carries black
    fifo_beat.pixel <= s1_item.de ? bank_rdata[s1_item.bank] : '0;
  end

endmodule

// File: src/vga_pkg.sv
`include "gfx_defines.svh"

package vga_pkg;

  // one raster position of the scan, syncs active low
  typedef struct packed {
    logic                          hsync;
    logic                          vsync;
    logic                          de;
    logic [$clog2(`GFX_NUM_S)-1:0] bank;
    logic [`GFX_WORD_BITS-1:0]     word;
  } scan_item_t;

  // fifo entry and display output
  typedef struct packed {
    logic           hsync;
    logic           vsync;
    logic           de;
    fb_pkg::pixel_t pixel;
  } vga_beat_t;

  // phase of a line or of a frame
  typedef enum logic [1:0] {
    st_active,
    st_front,
    st_sync,
    st_back
  } scan_state_e;

endpackage

// File: tb/gfx_golden.txt
# op x y colour, colour in hex as red green blue nibbles
# W overwrites a pixel after the fill, C gives the pixel value expected on screen
W 0 0 fff
W 15 0 f00
W 1 0 0f0
W 0 7 00f
W 15 7 123
W 7 3 abc
W 8 3 def
W 7 4 456
W 3 5 789
W 0 0 a5a
W 9 1 0ff
W 10 1 f0f
W 11 1 ff0
W 12 6 321
W 13 6 654
W 7 3 999
C 0 0 a5a
C 7 3 999
C 15 7 123
C 10 1 f0f

// File: tb/gfx_vga_stripe_chk.sv
`timescale 1ns/1ns
`include "gfx_defines.svh"

module gfx_vga_stripe_chk (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               gfx_valid,
  input logic                               gfx_ready,
  input fb_pkg::bank_req_t [`GFX_NUM_S-1:0] bank_req,
  input logic                               scan_step,
  input logic                               fifo_afull,
  input logic                               fifo_push,
  input vga_pkg::vga_beat_t                 fifo_beat
);
  logic [`GFX_NUM_S-1:0] wr_ops;

  for (genvar b = 0; b < `GFX_NUM_S; b++) begin : gen_wr_ops
    assign wr_ops[b] = (bank_req[b].op == fb_pkg::op_write);
  end

  // one op per bank, so a taken write is held back by at most one scan read
  assert property (@(posedge clk) disable iff (!rst_n)
    ($past(gfx_valid && gfx_ready, 2) && !$past(|wr_ops)) |-> $onehot(wr_ops))
    else $error("drawing write did not reach a bank within two cycles");

  // no push without a step since afull was seen
  assert property (@(posedge clk) disable iff (!rst_n)
    ($past(fifo_afull, 3) && !$past(scan_step, 2) && !$past(scan_step, 1)) |-> !fifo_push)
    else $error("fifo push while the scan was stalled");

  // blanking during sync
  assert property (@(posedge clk) disable iff (!rst_n)
    (fifo_push && (!fifo_beat.hsync || !fifo_beat.vsync)) |-> !fifo_beat.de)
    else $error("pushed beat has de high inside a sync pulse");

endmodule

// File: tb/tb_gfx_vga_stripe.sv
`timescale 1ns/1ns
`include "gfx_defines.svh"

module tb_gfx_vga_stripe;
  localparam int NPIX  = `GFX_H_VISIBLE * `GFX_V_VISIBLE;
  localparam int FRAME = `GFX_H_WHOLE * `GFX_V_WHOLE * `GFX_PIXEL_DIV;
  localparam int LIMIT = NPIX + 16 + 3 * FRAME + 200;

  logic               clk;
  logic               rst_n;
  logic               vga_enable;
  fb_pkg::gfx_write_t gfx_wr;
  logic               gfx_valid;
  logic               gfx_ready;
  vga_pkg::vga_beat_t vga_out;

  logic [11:0] model [NPIX];
  logic [11:0] shown [NPIX];
  int          gold_idx [$];
  logic [11:0] gold_val [$];
  integer      seed = 32'h091c_6119;
  int          errors = 0;
  int          cycles = 0;
  bit          writes_done = 0;
  bit          frame_on = 0;
  int          frames_done = 0;
  int          pix_idx = 0;
  bit          pop_seen = 0;
  vga_pkg::vga_beat_t prev_beat;
  int          line_de = 0;
  int          de_lines = 0;
  int          hs_run = 0;
  int          vs_run = 0;

  gfx_vga_stripe u_gfx_vga_stripe (
    .clk        (clk),
    .rst_n      (rst_n),
    .vga_enable (vga_enable),
    .gfx_wr     (gfx_wr),
    .gfx_valid  (gfx_valid),
    .gfx_ready  (gfx_ready),
    .vga_out    (vga_out)
  );

  bind stripe_ctrl gfx_vga_stripe_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .gfx_valid  (gfx_valid),
    .gfx_ready  (gfx_ready),
    .bank_req   (bank_req),
    .scan_step  (scan_step),
    .fifo_afull (fifo_afull),
    .fifo_push  (fifo_push),
    .fifo_beat  (fifo_beat)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, display did not finish", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // hold the write until the DUT takes it
  task automatic draw(input int x, input int y, input logic [11:0] color);
    int waited;
    waited = 0;
    @(negedge clk);
    gfx_wr.x     = `GFX_X_BITS'(x);
    gfx_wr.y     = `GFX_Y_BITS'(y);
    gfx_wr.color = color;
    gfx_valid    = 1'b1;
    while (!gfx_ready) begin
      @(negedge clk);
      waited++;
      if (waited == 100) begin
        errors++;
        $display("drawing write to %0d,%0d was not accepted in 100 cycles", x, y);
      end
    end
  endtask

  // one beat per fifo pop, raster numbered from the vsync rising edge
  task automatic take_beat(input vga_pkg::vga_beat_t b);
    if (b.de && frame_on && pix_idx < NPIX) begin
      check_value($sformatf("pixel %0d", pix_idx), 32'(b.pixel), 32'(model[pix_idx]));
      shown[pix_idx] = b.pixel;
      pix_idx++;
    end
    if (b.de) begin
      line_de++;
    end
    if (prev_beat.de && !b.de) begin
      check_value("de pixels per line", line_de, `GFX_H_VISIBLE);
      line_de = 0;
      de_lines++;
    end
    if (!b.hsync) begin
      hs_run++;
    end else if (!prev_beat.hsync) begin
      check_value("hsync ticks", hs_run, `GFX_H_SYNC);
      hs_run = 0;
    end
    if (!b.vsync) begin
      vs_run++;
    end else if (!prev_beat.vsync) begin
      check_value("vsync ticks", vs_run, `GFX_V_SYNC * `GFX_H_WHOLE);
      if (frame_on) begin
        check_value("de lines per frame", de_lines, `GFX_V_VISIBLE);
        check_value("pixels per frame", pix_idx, NPIX);
        frames_done++;
      end
      vs_run   = 0;
      de_lines = 0;
      pix_idx  = 0;
      frame_on = writes_done;
    end
    prev_beat = b;
  endtask

  // pop is seen mid cycle, the popped beat one cycle later
  always @(negedge clk) begin
    if (!rst_n) begin
      pop_seen = 0;
    end else begin
      if (pop_seen) begin
        take_beat(vga_out);
      end
      pop_seen = u_gfx_vga_stripe.u_fifo.pop;
    end
  end

  initial begin
    int          fd;
    int          r;
    int          x;
    int          y;
    logic [11:0] c;
    logic [63:0] op;
    logic [799:0] rest;
    clk        = 1'b0;
    rst_n      = 1'b0;
    vga_enable = 1'b1;
    gfx_valid  = 1'b0;
    gfx_wr     = '0;
    prev_beat  = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, pixel: '0};
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // reset state of the outputs
    check_value("ready right after reset", gfx_ready, 1'b0);
    check_value("hsync after reset", vga_out.hsync, 1'b1);
    check_value("vsync after reset", vga_out.vsync, 1'b1);
    check_value("de after reset", vga_out.de, 1'b0);
    @(negedge clk);
    check_value("ready second cycle", gfx_ready, 1'b1);
    check_value("de second cycle", vga_out.de, 1'b0);

    // whole frame while the scan is running
    for (int i = 0; i < NPIX; i++) begin
      model[i] = 12'($random(seed));
      draw(i % `GFX_H_VISIBLE, i / `GFX_H_VISIBLE, model[i]);
    end

    fd = $fopen("tb/gfx_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open tb/gfx_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        op = '0;
        r  = $fscanf(fd, " %s", op);
        if (r != 1) begin
          break;
        end
        if (op == "#") begin
          r = $fgets(rest, fd);
        end else begin
          r = $fscanf(fd, "%d %d %h", x, y, c);
          if (op == "W") begin
            model[y * `GFX_H_VISIBLE + x] = c;
            draw(x, y, c);
          end else if (op == "C") begin
            gold_idx.push_back(y * `GFX_H_VISIBLE + x);
            gold_val.push_back(c);
          end
        end
      end
      $fclose(fd);
    end
    @(negedge clk);
    gfx_valid   = 1'b0;
    writes_done = 1;

    // first full frame, then a stall in the middle of the next
    while (frames_done < 1) begin
      @(negedge clk);
    end
    while (!(frame_on && pix_idx >= 60 && pix_idx < NPIX)) begin
      @(negedge clk);
    end
    vga_enable = 1'b0;
    repeat (100) @(negedge clk);
    vga_enable = 1'b1;
    while (frames_done < 2) begin
      @(negedge clk);
    end

    // golden pixels against the last captured frame
    for (int i = 0; i < gold_idx.size(); i++) begin
      check_value($sformatf("golden %0d,%0d", gold_idx[i] % `GFX_H_VISIBLE,
                            gold_idx[i] / `GFX_H_VISIBLE),
                  32'(shown[gold_idx[i]]), 32'(gold_val[i]));
    end

    $display("errors: %0d, frames checked: %0d", errors, frames_done);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
